//--- hdl/ext_mem_pkg.sv
package ext_mem_pkg;

   // Bus widths
   localparam int addr_w = 16;          // Byte address
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // Cache geometry with one word per line
   localparam int index_w = 6;
   localparam int lines   = 1 << index_w;
   localparam int tag_w   = addr_w - index_w - 2;

   // Write-through buffer
   localparam int wtb_depth = 4;
   localparam int wtb_ptr_w = $clog2(wtb_depth);

   // Merge grant encoding
   localparam logic [1:0] gnt_none  = 2'b00;
   localparam logic [1:0] gnt_instr = 2'b01;
   localparam logic [1:0] gnt_data  = 2'b10;

   // One posted write
   typedef struct packed {
      logic [addr_w-3:0] addr;          // Word address
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } wtb_entry_t;

endpackage

//--- hdl/native_bus_if.sv
`timescale 1ns/1ps

interface native_bus_if
   import ext_mem_pkg::*;
   ();

   logic              valid;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;  // All zero for a read
   logic [data_w-1:0] rdata;
   logic              ready;  // One-cycle pulse

   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

//--- hdl/bus_merge.sv
`timescale 1ns/1ps

module bus_merge
   import ext_mem_pkg::*;
(
   input logic          clk,
   input logic          rst,
   native_bus_if.slave  i_bus,
   native_bus_if.slave  d_bus,
   native_bus_if.master c_bus
);

   logic [1:0] grant;  // Locked owner
   logic [1:0] sel;    // Owner in this cycle

   // Free choice only while unlocked
   always_comb begin
      if (grant != gnt_none)
         sel = grant;
      else if (d_bus.valid)
         sel = gnt_data;   // Data wins
      else if (i_bus.valid)
         sel = gnt_instr;
      else
         sel = gnt_none;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         grant <= gnt_none;
      else if (c_bus.ready)
         grant <= gnt_none;  // Release on the response
      else
         grant <= sel;
   end

   always_comb begin
      case (sel)
         gnt_data: begin
            c_bus.valid = d_bus.valid;
            c_bus.addr  = d_bus.addr;
            c_bus.wdata = d_bus.wdata;
            c_bus.wstrb = d_bus.wstrb;
         end
         gnt_instr: begin
            c_bus.valid = i_bus.valid;
            c_bus.addr  = i_bus.addr;
            c_bus.wdata = i_bus.wdata;
            c_bus.wstrb = i_bus.wstrb;
         end
         default: begin
            c_bus.valid = 1'b0;
            c_bus.addr  = '0;
            c_bus.wdata = '0;
            c_bus.wstrb = '0;
         end
      endcase
   end

   assign d_bus.rdata = (sel == gnt_data) ? c_bus.rdata : '0;
   assign d_bus.ready = (sel == gnt_data) && c_bus.ready;
   assign i_bus.rdata = (sel == gnt_instr) ? c_bus.rdata : '0;
   assign i_bus.ready = (sel == gnt_instr) && c_bus.ready;

   // A locked owner keeps its request up until the response
   assert property (@(posedge clk) disable iff (rst) (grant != gnt_none) |-> c_bus.valid);

endmodule

//--- hdl/line_cache.sv
`timescale 1ns/1ps

module line_cache
   import ext_mem_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         flush,
   native_bus_if.slave  c_bus,
   native_bus_if.master m_bus
);

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_fill,
      st_wr_fwd,
      st_respond
   } state_t;

   state_t state;

   logic [tag_w-1:0]  tag_mem  [lines];
   logic [data_w-1:0] data_mem [lines];
   logic [lines-1:0]  valid_bits;

   // Array outputs, read while idle
   logic [tag_w-1:0]  tag_rd;
   logic [data_w-1:0] data_rd;
   logic              vld_rd;
   logic [data_w-1:0] rdata_q;  // Fill word for the response

   logic [index_w-1:0] idx;
   logic [tag_w-1:0]   tag;
   logic               is_write;
   logic               hit;

   // Request stays steady until ready
   assign idx      = c_bus.addr[index_w+1:2];
   assign tag      = c_bus.addr[addr_w-1 -: tag_w];
   assign is_write = |c_bus.wstrb;
   assign hit      = vld_rd && (tag_rd == tag);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= st_idle;
         m_bus.valid <= 1'b0;
         valid_bits  <= '0;
      end else begin
         case (state)
            st_idle:
               if (c_bus.valid)
                  state <= st_lookup;
            st_lookup:
               if (is_write) begin
                  m_bus.valid <= 1'b1;  // Every write goes downstream
                  state       <= st_wr_fwd;
               end else if (hit) begin
                  state <= st_idle;
               end else begin
                  m_bus.valid <= 1'b1;
                  state       <= st_fill;
               end
            st_fill:
               if (m_bus.ready) begin
                  m_bus.valid     <= 1'b0;
                  valid_bits[idx] <= 1'b1;
                  state           <= st_respond;
               end
            st_wr_fwd:
               if (m_bus.ready) begin
                  m_bus.valid <= 1'b0;
                  state       <= st_respond;
               end
            st_respond:
               state <= st_idle;
            default:
               state <= st_idle;
         endcase
         if (flush)
            valid_bits <= '0;  // Bulk invalidate
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         tag_rd  <= tag_mem[idx];
         data_rd <= data_mem[idx];
         vld_rd  <= valid_bits[idx];
      end
      if (state == st_lookup) begin
         m_bus.addr  <= {c_bus.addr[addr_w-1:2], 2'b00};
         m_bus.wdata <= c_bus.wdata;
         m_bus.wstrb <= c_bus.wstrb;
         // Byte merge on a write hit, no allocate on a miss
         if (is_write && hit) begin
            for (int b = 0; b < strb_w; b++) begin
               if (c_bus.wstrb[b])
                  data_mem[idx][8*b +: 8] <= c_bus.wdata[8*b +: 8];
            end
         end
      end
      if (state == st_fill && m_bus.ready) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= m_bus.rdata;
         rdata_q       <= m_bus.rdata;
      end
   end

   // Hit answers straight from lookup
   assign c_bus.ready = (state == st_lookup && hit && !is_write) || (state == st_respond);
   assign c_bus.rdata = (state == st_respond) ? rdata_q : data_rd;

   // Responses only to a live request from the merge
   assert property (@(posedge clk) disable iff (rst) c_bus.ready |-> c_bus.valid);

endmodule

//--- hdl/wt_buffer.sv
`timescale 1ns/1ps

module wt_buffer
   import ext_mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   native_bus_if.slave       m_bus,
   output logic              mem_valid,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   output logic [strb_w-1:0] mem_wstrb,
   input  logic [data_w-1:0] mem_rdata,
   input  logic              mem_ready
);

   wtb_entry_t fifo [wtb_depth];
   wtb_entry_t head;

   logic [wtb_ptr_w-1:0] wr_ptr;
   logic [wtb_ptr_w-1:0] rd_ptr;
   logic [wtb_ptr_w:0]   count;

   logic full;
   logic empty;
   logic is_write;
   logic push;
   logic pop;
   logic rd_active;  // Read on the memory port
   logic ready_q;
   logic [data_w-1:0] rdata_q;

   assign full     = count == (wtb_ptr_w + 1)'(wtb_depth);
   assign empty    = count == '0;
   assign is_write = |m_bus.wstrb;
   assign push     = m_bus.valid && is_write && !full && !ready_q;
   assign pop      = !empty && mem_ready;
   // Reads wait for the drain so they never pass a write
   assign rd_active = m_bus.valid && !is_write && empty && !ready_q;
   assign head      = fifo[rd_ptr];

   // Drain first, then the pending read
   always_comb begin
      if (!empty) begin
         mem_valid = 1'b1;
         mem_addr  = {head.addr, 2'b00};
         mem_wdata = head.data;
         mem_wstrb = head.strb;
      end else begin
         mem_valid = rd_active;
         mem_addr  = m_bus.addr;
         mem_wdata = m_bus.wdata;
         mem_wstrb = '0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         ready_q <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count   <= count + push - pop;
         ready_q <= push || (rd_active && mem_ready);
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         fifo[wr_ptr] <= '{addr: m_bus.addr[addr_w-1:2], data: m_bus.wdata, strb: m_bus.wstrb};
      if (rd_active && mem_ready)
         rdata_q <= mem_rdata;
   end

   assign m_bus.ready = ready_q;
   assign m_bus.rdata = rdata_q;

   // Pointer distance matches the entry count
   assert property (@(posedge clk) disable iff (rst)
      count[wtb_ptr_w-1:0] == (wr_ptr - rd_ptr));

   // Memory answers only what was presented, so an empty FIFO never pops
   assert property (@(posedge clk) disable iff (rst) mem_ready |-> mem_valid);

endmodule

//--- hdl/ext_mem.sv
`timescale 1ns/1ps

module ext_mem
   import ext_mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              invalidate,
   input  logic              i_valid,
   input  logic [addr_w-1:0] i_addr,
   output logic [data_w-1:0] i_rdata,
   output logic              i_ready,
   input  logic              d_valid,
   input  logic [addr_w-1:0] d_addr,
   input  logic [data_w-1:0] d_wdata,
   input  logic [strb_w-1:0] d_wstrb,
   output logic [data_w-1:0] d_rdata,
   output logic              d_ready,
   output logic              mem_valid,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   output logic [strb_w-1:0] mem_wstrb,
   input  logic [data_w-1:0] mem_rdata,
   input  logic              mem_ready
);

   native_bus_if i_bus ();
   native_bus_if d_bus ();
   native_bus_if c_bus ();
   native_bus_if m_bus ();

   logic inv_hold;  // Pending invalidate
   logic flush;

   // Instruction side is read only
   assign i_bus.valid = i_valid;
   assign i_bus.addr  = i_addr;
   assign i_bus.wdata = '0;
   assign i_bus.wstrb = '0;
   assign i_rdata     = i_bus.rdata;
   assign i_ready     = i_bus.ready;

   assign d_bus.valid = d_valid;
   assign d_bus.addr  = d_addr;
   assign d_bus.wdata = d_wdata;
   assign d_bus.wstrb = d_wstrb;
   assign d_rdata     = d_bus.rdata;
   assign d_ready     = d_bus.ready;

   // Hold the invalidate until no request is in flight on the cache
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         inv_hold <= 1'b0;
      else if (invalidate)
         inv_hold <= 1'b1;
      else if (!c_bus.valid)
         inv_hold <= 1'b0;
   end

   assign flush = inv_hold && !c_bus.valid;

   bus_merge u_bus_merge (
      .clk   (clk),
      .rst   (rst),
      .i_bus (i_bus),
      .d_bus (d_bus),
      .c_bus (c_bus)
   );

   line_cache u_line_cache (
      .clk   (clk),
      .rst   (rst),
      .flush (flush),
      .c_bus (c_bus),
      .m_bus (m_bus)
   );

   wt_buffer u_wt_buffer (
      .clk       (clk),
      .rst       (rst),
      .m_bus     (m_bus),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

//--- bench/ext_mem_tb.sv
`timescale 1ns/1ps

module ext_mem_tb
   import ext_mem_pkg::*;
();

   localparam int words       = 1 << (addr_w - 2);
   localparam int log_w       = (addr_w - 2) + data_w + strb_w;
   localparam int n_ops       = 17;  // Bus accesses over all tests
   localparam int worst_lat   = 48;  // Read behind a full buffer at the slowest memory
   localparam int cycle_limit = 8 + 40 + n_ops * worst_lat;

   logic              clk = 1'b0;
   logic              rst;
   logic              invalidate;
   logic              i_valid;
   logic [addr_w-1:0] i_addr;
   logic [data_w-1:0] i_rdata;
   logic              i_ready;
   logic              d_valid;
   logic [addr_w-1:0] d_addr;
   logic [data_w-1:0] d_wdata;
   logic [strb_w-1:0] d_wstrb;
   logic [data_w-1:0] d_rdata;
   logic              d_ready;
   logic              mem_valid;
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic [strb_w-1:0] mem_wstrb;
   logic [data_w-1:0] mem_rdata;
   logic              mem_ready;

   logic [data_w-1:0] mem_model [words];
   logic [data_w-1:0] shadow [words];  // Expected memory content
   logic [31:0]       lfsr = 32'h833ebb64;
   logic              slow_mem;        // Forces the longest memory delay
   logic [addr_w-3:0] rd_log [$];
   logic [log_w-1:0]  wr_log [$];      // Word address, data, strobes
   int                mem_reads;
   int                n_checks;
   int                n_errors;
   int                cycles;

   always #4 clk = ~clk;

   ext_mem dut (.*);

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
   endfunction

   // Memory fill pattern over the whole word address
   function automatic logic [data_w-1:0] init_word(input logic [addr_w-3:0] wa);
      return {wa[7:0] ^ 8'ha5, 2'b01, ~wa, wa[7:0]};
   endfunction

   function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old,
         input logic [data_w-1:0] wdata, input logic [strb_w-1:0] strb);
      logic [data_w-1:0] res;
      res = old;
      for (int b = 0; b < strb_w; b++)
         if (strb[b])
            res[8*b +: 8] = wdata[8*b +: 8];
      return res;
   endfunction

   task automatic take_bits(input int n, output logic [3:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = lfsr[0];  // One step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      n_checks++;
      assert (got === exp) else begin
         $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         n_errors++;
      end
   endtask

   // Called and returns 1 ns after a rising edge
   task automatic d_access(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
         input logic [strb_w-1:0] strb, output logic [data_w-1:0] rdata);
      d_valid = 1'b1;
      d_addr  = addr;
      d_wdata = wdata;
      d_wstrb = strb;
      @(negedge clk);
      while (!d_ready)
         @(negedge clk);
      rdata = d_rdata;
      @(posedge clk);
      #1;
      d_valid = 1'b0;
   endtask

   task automatic i_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] rdata);
      i_valid = 1'b1;
      i_addr  = addr;
      @(negedge clk);
      while (!i_ready)
         @(negedge clk);
      rdata = i_rdata;
      @(posedge clk);
      #1;
      i_valid = 1'b0;
   endtask

   task automatic d_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
         input logic [strb_w-1:0] strb);
      logic [data_w-1:0] unused;
      shadow[addr[addr_w-1:2]] = merge_bytes(shadow[addr[addr_w-1:2]], data, strb);
      d_access(addr, data, strb, unused);
   endtask

   task automatic d_read_expect(input logic [addr_w-1:0] addr, input string what);
      logic [data_w-1:0] rd;
      d_access(addr, '0, '0, rd);
      check_eq(what, rd, shadow[addr[addr_w-1:2]]);
   endtask

   // Buffer is empty once mem_valid stays low
   task automatic wait_quiet();
      int idle;
      idle = 0;
      while (idle < 2) begin
         @(negedge clk);
         idle = mem_valid ? 0 : idle + 1;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic read_miss_then_hit();
      int reads0;
      reads0 = mem_reads;
      d_read_expect(16'h0100, "read miss data");
      check_eq("memory reads after miss", mem_reads - reads0, 1);
      d_read_expect(16'h0100, "read hit data");
      check_eq("memory reads after hit", mem_reads - reads0, 1);
   endtask

   task automatic strobed_writes();
      d_write(16'h0100, 32'hdeadbeef, 4'b0101);  // Hit line
      d_write(16'h0240, 32'h12345678, 4'b1100);  // Miss line
      d_read_expect(16'h0100, "write hit readback");
      d_read_expect(16'h0240, "write miss readback");
      wait_quiet();
      check_eq("model after hit write", mem_model[16'h0100 >> 2], shadow[16'h0100 >> 2]);
      check_eq("model after miss write", mem_model[16'h0240 >> 2], shadow[16'h0240 >> 2]);
   endtask

   task automatic same_cycle_reads();
      logic [data_w-1:0] d_rd;
      logic [data_w-1:0] i_rd;
      rd_log.delete();
      fork
         d_access(16'h0300, '0, '0, d_rd);
         i_read(16'h0404, i_rd);
      join
      check_eq("data word", d_rd, shadow[16'h0300 >> 2]);
      check_eq("instruction word", i_rd, shadow[16'h0404 >> 2]);
      check_eq("memory reads seen", rd_log.size(), 2);
      check_eq("first memory read address", rd_log[0], 16'h0300 >> 2);
   endtask

   task automatic invalidate_refetch();
      int reads0;
      reads0 = mem_reads;
      mem_model[16'h0300 >> 2] = ~shadow[16'h0300 >> 2];  // Behind the cache
      d_read_expect(16'h0300, "stale read before invalidate");
      check_eq("memory reads before invalidate", mem_reads - reads0, 0);
      shadow[16'h0300 >> 2] = mem_model[16'h0300 >> 2];
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      d_read_expect(16'h0300, "read after invalidate");
      check_eq("memory reads after invalidate", mem_reads - reads0, 1);
   endtask

   task automatic back_to_back_writes();
      logic [addr_w-1:0] addrs [6] = '{16'h0500, 16'h0504, 16'h0500, 16'h0508, 16'h050c,
                                       16'h0500};
      logic [log_w-1:0]  exp_log [$];
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      slow_mem = 1'b1;
      wr_log.delete();
      for (int i = 0; i < 6; i++) begin
         data = 32'ha0a0a0a0 + i * 32'h01010101;
         strb = (i == 2) ? 4'b0011 : 4'hf;
         exp_log.push_back({addrs[i][addr_w-1:2], data, strb});
         d_write(addrs[i], data, strb);
      end
      d_read_expect(16'h0500, "read after back-to-back writes");
      wait_quiet();
      slow_mem = 1'b0;
      check_eq("writes at memory", wr_log.size(), 6);
      for (int i = 0; i < 6 && i < wr_log.size(); i++)
         check_eq("write order at memory", wr_log[i], exp_log[i]);
      check_eq("model after writes", mem_model[16'h0500 >> 2], shadow[16'h0500 >> 2]);
   endtask

   // Memory port model with 0 to 3 cycles of extra delay
   initial begin
      logic [3:0]        dly;
      logic [addr_w-3:0] wa;
      forever begin
         @(negedge clk);
         if (mem_valid === 1'b1 && !rst) begin
            if (slow_mem)
               dly = 4'd3;
            else
               take_bits(2, dly);
            repeat (dly) @(negedge clk);
            @(posedge clk);
            #1;
            wa = mem_addr[addr_w-1:2];
            if (mem_wstrb == '0) begin
               mem_reads++;
               rd_log.push_back(wa);
               mem_rdata = mem_model[wa];
            end else begin
               mem_model[wa] = merge_bytes(mem_model[wa], mem_wdata, mem_wstrb);
               wr_log.push_back({wa, mem_wdata, mem_wstrb});
            end
            mem_ready = 1'b1;
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rst        = 1'b1;
      invalidate = 1'b0;
      i_valid    = 1'b0;
      i_addr     = '0;
      d_valid    = 1'b0;
      d_addr     = '0;
      d_wdata    = '0;
      d_wstrb    = '0;
      mem_rdata  = '0;
      mem_ready  = 1'b0;
      slow_mem   = 1'b0;
      mem_reads  = 0;
      n_checks   = 0;
      n_errors   = 0;
      for (int w = 0; w < words; w++) begin
         mem_model[w] = init_word(w[addr_w-3:0]);
         shadow[w]    = init_word(w[addr_w-3:0]);
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      #1;
      read_miss_then_hit();
      strobed_writes();
      same_cycle_reads();
      invalidate_refetch();
      back_to_back_writes();
      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- compile.f
hdl/ext_mem_pkg.sv
hdl/native_bus_if.sv
hdl/bus_merge.sv
hdl/line_cache.sv
hdl/wt_buffer.sv
hdl/ext_mem.sv
bench/ext_mem_tb.sv
